//--- hw/dramCtrlPkg.sv
package dramCtrlPkg;

    //////////////////////////////////////////////////////////////////////
    // widths that carry a meaning
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] cpuAddrT;      // 68000 address bus
    typedef logic [15:0] wordT;         // one data word, cpu or sdram side
    typedef logic [12:0] dramAddrT;     // row / column address pins
    typedef logic [1:0]  bankT;         // bank address pins
    typedef logic [4:0]  dramCmdT;      // {cke, cs_l, ras_l, cas_l, we_l}
    typedef logic [15:0] timerT;        // either down-counter

    //////////////////////////////////////////////////////////////////////
    // sdram commands
    //////////////////////////////////////////////////////////////////////
    localparam dramCmdT CmdPowerUp      = 5'b00000;    // cke and cs low while supply settles
    localparam dramCmdT CmdNop          = 5'b10111;
    localparam dramCmdT CmdActivate     = 5'b10011;    // opens row on bank
    localparam dramCmdT CmdRead         = 5'b10101;    // A10 high gives auto precharge
    localparam dramCmdT CmdWrite        = 5'b10100;    // same, for write
    localparam dramCmdT CmdPrechargeAll = 5'b10010;    // needs A10 high
    localparam dramCmdT CmdAutoRefresh  = 5'b10001;
    localparam dramCmdT CmdModeSet      = 5'b10000;    // mode reg value on the address pins

    // cpu address slices, word addressed so bit 0 is dropped
    localparam int RowMsb  = 23;
    localparam int RowLsb  = 11;
    localparam int BankMsb = 25;
    localparam int BankLsb = 24;
    localparam int ColMsb  = 10;
    localparam int ColLsb  = 1;

    localparam dramAddrT AutoPrechargeAddr = 13'h0400;    // A10 only
    localparam dramAddrT ModeRegValue      = 13'h0220;    // cas latency 2, burst 1

    //////////////////////////////////////////////////////////////////////
    // timer preloads, shortened for simulation
    //////////////////////////////////////////////////////////////////////
    localparam timerT PowerUpDelay      = 16'd7;
    localparam timerT CmdGapDelay       = 16'd2;      // trc, tmrd and the cas wait
    localparam timerT InitRefreshWindow = 16'd39;     // back-to-back refreshes at init
    localparam timerT RefreshPeriod     = 16'd375;

    // sequencer states
    typedef enum logic [4:0] {
        InitEnter,              // load power-up wait
        InitWaitPowerUp,
        InitFirstNop,
        InitPrechargeAll,
        InitPostPrechargeNop,   // arms the init refresh window
        InitRefresh,
        InitPostRefreshNop,
        InitModeSet,
        InitPostModeNop,
        Idle,
        RefPrecharge,
        RefNop,
        RefIssue,
        RefRecover,
        ReadCmd,
        ReadCasWait,
        WriteWaitStrobe,
        WriteHold,
        Terminate               // waits for cpu to drop its strobes
    } seqStateT;

endpackage

//--- hw/dramTimers.sv
`timescale 1ns/1ps

module dramTimers (
    input  logic                Clock,
    input  logic                Reset_L,
    input  logic                timerLoad,      // general delay preload strobe
    input  dramCtrlPkg::timerT  timerValue,
    input  logic                refreshLoad,    // refresh interval preload strobe
    input  dramCtrlPkg::timerT  refreshValue,
    output logic                timerDone,
    output logic                refreshDone
);
    import dramCtrlPkg::*;

    // index 0 is the general timer, index 1 the refresh interval
    timerT count [2];
    logic  load  [2];
    timerT value [2];

    assign load[0]  = timerLoad;
    assign load[1]  = refreshLoad;
    assign value[0] = timerValue;
    assign value[1] = refreshValue;

    //////////////////////////////////////////////////////////////////////
    // two loadable down-counters that park at zero
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int i = 0; i < 2; i++) begin
                count[i] <= '0;                     // both start expired
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (load[i]) begin
                    count[i] <= value[i];           // load wins over the decrement
                end else if (count[i] != '0) begin
                    count[i] <= count[i] - 16'd1;
                end
            end
        end
    end

    assign timerDone   = (count[0] == '0);  // done for as long as the count sits at zero
    assign refreshDone = (count[1] == '0);

endmodule

//--- hw/dramSequencer.sv
`timescale 1ns/1ps

module dramSequencer (
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  dramCtrlPkg::cpuAddrT  Address,
    input  dramCtrlPkg::wordT     DataIn,
    input  logic                  UDS_L,
    input  logic                  LDS_L,
    input  logic                  DramSelect_L,
    input  logic                  WE_L,
    input  logic                  AS_L,
    input  logic                  timerDone,
    input  logic                  refreshDone,
    output logic                  timerLoad,
    output logic                  refreshLoad,
    output dramCtrlPkg::timerT    timerValue,
    output dramCtrlPkg::timerT    refreshValue,
    output dramCtrlPkg::dramCmdT  command,
    output dramCtrlPkg::dramAddrT dramAddr,
    output dramCtrlPkg::bankT     bank,
    output dramCtrlPkg::wordT     writeData,
    output logic                  writeEnable,    // drives dq in the pin stage
    output logic                  dataLatch,      // capture read data on next falling edge
    output logic                  dtackN,
    output logic                  cpuResetN
);
    import dramCtrlPkg::*;

    seqStateT state;
    seqStateT nextState;

    dramAddrT rowAddr;
    dramAddrT colAddr;
    bankT     bankAddr;
    logic     cpuCycleReq;
    logic     strobeLow;

    //////////////////////////////////////////////////////////////////////
    // cpu side decode
    //////////////////////////////////////////////////////////////////////
    assign rowAddr  = Address[RowMsb:RowLsb];
    assign bankAddr = Address[BankMsb:BankLsb];
    assign colAddr  = dramAddrT'(Address[ColMsb:ColLsb]) | AutoPrechargeAddr;  // A10 for auto precharge

    assign cpuCycleReq = !AS_L && !DramSelect_L;    // address valid and we are selected
    assign strobeLow   = !UDS_L || !LDS_L;          // either byte lane active

    // state register
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state <= InitEnter;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and command decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState    = state;
        command      = CmdNop;
        dramAddr     = '0;
        bank         = '0;
        writeData    = '0;
        writeEnable  = 1'b0;
        dataLatch    = 1'b0;
        dtackN       = 1'b1;
        cpuResetN    = 1'b1;
        timerLoad    = 1'b0;
        timerValue   = '0;
        refreshLoad  = 1'b0;
        refreshValue = '0;

        case (state)
            // power-up: cke low, cpu held in reset
            InitEnter: begin
                cpuResetN  = 1'b0;
                command    = CmdPowerUp;
                timerValue = PowerUpDelay;
                timerLoad  = 1'b1;
                nextState  = InitWaitPowerUp;
            end
            InitWaitPowerUp: begin
                cpuResetN = 1'b0;
                command   = CmdPowerUp;
                if (timerDone) begin
                    nextState = InitFirstNop;
                end
            end
            InitFirstNop: begin
                cpuResetN = 1'b0;                   // first cycle with cke high
                nextState = InitPrechargeAll;
            end
            InitPrechargeAll: begin
                cpuResetN = 1'b0;
                command   = CmdPrechargeAll;
                dramAddr  = AutoPrechargeAddr;
                nextState = InitPostPrechargeNop;
            end
            InitPostPrechargeNop: begin
                cpuResetN    = 1'b0;
                refreshValue = InitRefreshWindow;   // refresh repeatedly until this runs out
                refreshLoad  = 1'b1;
                nextState    = InitRefresh;
            end
            InitRefresh: begin
                cpuResetN  = 1'b0;
                command    = CmdAutoRefresh;
                timerValue = CmdGapDelay;
                timerLoad  = 1'b1;
                nextState  = InitPostRefreshNop;
            end
            InitPostRefreshNop: begin
                cpuResetN = 1'b0;
                if (refreshDone) begin
                    nextState = InitModeSet;
                end else if (timerDone) begin
                    nextState = InitRefresh;        // trc met, go again
                end
            end
            InitModeSet: begin
                cpuResetN  = 1'b0;
                command    = CmdModeSet;
                dramAddr   = ModeRegValue;
                timerValue = CmdGapDelay;           // tmrd
                timerLoad  = 1'b1;
                nextState  = InitPostModeNop;
            end
            InitPostModeNop: begin
                cpuResetN = 1'b0;
                if (timerDone) begin
                    nextState = Idle;
                end
            end

            // cpu cycle takes priority, refresh only when bus is quiet
            Idle: begin
                if (cpuCycleReq) begin
                    command   = CmdActivate;
                    dramAddr  = rowAddr;
                    bank      = bankAddr;
                    nextState = WE_L ? ReadCmd : WriteWaitStrobe;
                end else if (refreshDone) begin
                    refreshValue = RefreshPeriod;
                    refreshLoad  = 1'b1;
                    nextState    = RefPrecharge;
                end
            end

            // periodic refresh
            RefPrecharge: begin
                command   = CmdPrechargeAll;
                dramAddr  = AutoPrechargeAddr;
                nextState = RefNop;
            end
            RefNop: begin
                nextState = RefIssue;               // trp
            end
            RefIssue: begin
                command    = CmdAutoRefresh;
                timerValue = CmdGapDelay;
                timerLoad  = 1'b1;
                nextState  = RefRecover;
            end
            RefRecover: begin
                if (timerDone) begin
                    nextState = Idle;
                end
            end

            // read, one cycle after activate
            ReadCmd: begin
                command    = CmdRead;
                dramAddr   = colAddr;
                bank       = bankAddr;
                timerValue = CmdGapDelay;           // cas latency
                timerLoad  = 1'b1;
                nextState  = ReadCasWait;
            end
            ReadCasWait: begin
                dtackN = 1'b0;
                if (timerDone) begin
                    dataLatch = 1'b1;               // dq valid now
                    nextState = Terminate;
                end
            end

            // write waits for a data strobe, data is valid from then on
            WriteWaitStrobe: begin
                if (strobeLow) begin
                    command     = CmdWrite;
                    dramAddr    = colAddr;
                    bank        = bankAddr;
                    writeData   = DataIn;
                    writeEnable = 1'b1;
                    dtackN      = 1'b0;
                    nextState   = WriteHold;
                end
            end
            WriteHold: begin
                writeData   = DataIn;               // hold dq one more cycle
                writeEnable = 1'b1;
                dtackN      = 1'b0;
                nextState   = Terminate;
            end

            Terminate: begin
                if (strobeLow) begin
                    dtackN = 1'b0;                  // cpu not done yet
                end else begin
                    nextState = Idle;
                end
            end

            default: begin
                nextState = Idle;
            end
        endcase
    end

endmodule

//--- hw/dramPinDriver.sv
`timescale 1ns/1ps

module dramPinDriver (
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  dramCtrlPkg::dramCmdT  command,
    input  dramCtrlPkg::dramAddrT dramAddr,
    input  dramCtrlPkg::bankT     bank,
    input  dramCtrlPkg::wordT     writeData,
    input  logic                  writeEnable,
    input  logic                  dataLatch,
    input  logic                  dtackN,
    input  logic                  cpuResetN,
    input  dramCtrlPkg::wordT     SdramDqIn,
    output logic                  SdramCke,
    output logic                  SdramCs_L,
    output logic                  SdramRas_L,
    output logic                  SdramCas_L,
    output logic                  SdramWe_L,
    output dramCtrlPkg::dramAddrT SdramAddr,
    output dramCtrlPkg::bankT     SdramBa,
    output dramCtrlPkg::wordT     SdramDqOut,
    output logic                  SdramDqOe,
    output logic                  Dtack_L,
    output logic                  ResetOut_L,
    output dramCtrlPkg::wordT     DataOut
);
    import dramCtrlPkg::*;

    dramCmdT cmdQ;      // registered command, split onto pins below

    //////////////////////////////////////////////////////////////////////
    // control pins, one cycle behind the sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            cmdQ       <= CmdPowerUp;   // cke low out of reset
            SdramDqOe  <= 1'b0;
            Dtack_L    <= 1'b1;
            ResetOut_L <= 1'b0;         // cpu stays in reset until init ends
        end else begin
            cmdQ       <= command;
            SdramDqOe  <= writeEnable;
            Dtack_L    <= dtackN;
            ResetOut_L <= cpuResetN;
        end
    end

    // address and write data
    always_ff @(posedge Clock) begin
        SdramAddr  <= dramAddr;
        SdramBa    <= bank;
        SdramDqOut <= writeData;
    end

    assign {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} = cmdQ;

    // read data sampled mid-cycle, held until the next read
    always_ff @(negedge Clock) begin
        if (dataLatch) begin
            DataOut <= SdramDqIn;
        end
    end

endmodule

//--- hw/m68kDramController.sv
`timescale 1ns/1ps

module m68kDramController (
    input  logic                  Clock,
    input  logic                  Reset_L,
    // 68000 bus
    input  dramCtrlPkg::cpuAddrT  Address,
    input  dramCtrlPkg::wordT     DataIn,
    input  logic                  UDS_L,
    input  logic                  LDS_L,
    input  logic                  DramSelect_L,
    input  logic                  WE_L,
    input  logic                  AS_L,
    output dramCtrlPkg::wordT     DataOut,
    output logic                  Dtack_L,
    output logic                  ResetOut_L,
    // sdram pins
    output logic                  SdramCke,
    output logic                  SdramCs_L,
    output logic                  SdramRas_L,
    output logic                  SdramCas_L,
    output logic                  SdramWe_L,
    output dramCtrlPkg::dramAddrT SdramAddr,
    output dramCtrlPkg::bankT     SdramBa,
    output dramCtrlPkg::wordT     SdramDqOut,
    output logic                  SdramDqOe,      // pad buffer enable, board level
    input  dramCtrlPkg::wordT     SdramDqIn
);
    import dramCtrlPkg::*;

    logic     timerLoad;
    logic     refreshLoad;
    timerT    timerValue;
    timerT    refreshValue;
    logic     timerDone;
    logic     refreshDone;
    dramCmdT  command;
    dramAddrT dramAddr;
    bankT     bank;
    wordT     writeData;
    logic     writeEnable;
    logic     dataLatch;
    logic     dtackN;
    logic     cpuResetN;

    //////////////////////////////////////////////////////////////////////
    // timers, sequencer, output stage
    //////////////////////////////////////////////////////////////////////
    dramTimers i_timers (
        .Clock, .Reset_L,
        .timerLoad, .timerValue, .refreshLoad, .refreshValue,
        .timerDone, .refreshDone
    );

    dramSequencer i_sequencer (
        .Clock, .Reset_L,
        .Address, .DataIn, .UDS_L, .LDS_L, .DramSelect_L, .WE_L, .AS_L,
        .timerDone, .refreshDone,
        .timerLoad, .refreshLoad, .timerValue, .refreshValue,
        .command, .dramAddr, .bank, .writeData,
        .writeEnable, .dataLatch, .dtackN, .cpuResetN
    );

    dramPinDriver i_pinDriver (
        .Clock, .Reset_L,
        .command, .dramAddr, .bank, .writeData,
        .writeEnable, .dataLatch, .dtackN, .cpuResetN,
        .SdramDqIn,
        .SdramCke, .SdramCs_L, .SdramRas_L, .SdramCas_L, .SdramWe_L,
        .SdramAddr, .SdramBa, .SdramDqOut, .SdramDqOe,
        .Dtack_L, .ResetOut_L, .DataOut
    );

endmodule

//--- sim/sdramModel.sv
`timescale 1ns/1ps

module sdramModel (
    input  logic                  Clock,
    input  logic                  SdramCke,
    input  logic                  SdramCs_L,
    input  logic                  SdramRas_L,
    input  logic                  SdramCas_L,
    input  logic                  SdramWe_L,
    input  dramCtrlPkg::dramAddrT SdramAddr,
    input  dramCtrlPkg::bankT     SdramBa,
    input  dramCtrlPkg::wordT     SdramDqOut,
    input  logic                  SdramDqOe,
    output dramCtrlPkg::wordT     SdramDqIn
);
    import dramCtrlPkg::*;

    int          modelErrors = 0;
    logic        modeSet = 1'b0;
    logic        rowOpen [4] = '{4{1'b0}};
    dramAddrT    openRow [4];
    wordT        mem [logic [24:0]];    // sparse, keyed by {bank, row, col}
    logic        readPending = 1'b0;    // read taken on the last edge
    wordT        readWord;
    dramCmdT     pinCmd;
    logic [24:0] key;

    assign pinCmd = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};
    assign key    = {SdramBa, openRow[SdramBa], SdramAddr[9:0]};

    initial SdramDqIn = '0;

    // commands sampled on the edge after the controller drives them
    always @(posedge Clock) begin
        // data lands two pin cycles after the read went out
        if (readPending) begin
            SdramDqIn <= readWord;
            readPending = 1'b0;
        end
        case (pinCmd)
            CmdModeSet: modeSet = 1'b1;
            CmdPrechargeAll: begin
                for (int b = 0; b < 4; b++) rowOpen[b] = 1'b0;
            end
            CmdActivate: begin
                if (!modeSet) begin
                    modelErrors++;
                    $display("sdram model: activate before the mode register was set, at %0t",
                             $time);
                end
                rowOpen[SdramBa] = 1'b1;
                openRow[SdramBa] = SdramAddr;
            end
            CmdRead, CmdWrite: begin
                if (!modeSet || !rowOpen[SdramBa]) begin
                    modelErrors++;
                    $display("sdram model: access to closed bank %0d or before mode set, at %0t",
                             SdramBa, $time);
                end else if (pinCmd == CmdWrite) begin
                    if (!SdramDqOe) begin
                        modelErrors++;
                        $display("sdram model: write while the data bus is not driven, at %0t",
                                 $time);
                    end
                    mem[key] = SdramDqOut;
                end else begin
                    readWord    = mem.exists(key) ? mem[key]
                                                  : (key[15:0] ^ {key[24:16], key[6:0]});
                    readPending = 1'b1;
                end
                if (SdramAddr[10]) rowOpen[SdramBa] = 1'b0;    // auto precharge
            end
            default: ;
        endcase
    end

endmodule

//--- sim/m68kDramController_properties.sv
`timescale 1ns/1ps

module m68kDramController_properties (
    input logic                  Clock,
    input logic                  Reset_L,
    input dramCtrlPkg::cpuAddrT  Address,
    input logic                  UDS_L,
    input logic                  LDS_L,
    input logic                  Dtack_L,
    input logic                  ResetOut_L,
    input logic                  SdramCke,
    input logic                  SdramCs_L,
    input logic                  SdramRas_L,
    input logic                  SdramCas_L,
    input logic                  SdramWe_L,
    input dramCtrlPkg::dramAddrT SdramAddr,
    input dramCtrlPkg::bankT     SdramBa,
    input logic                  SdramDqOe
);
    import dramCtrlPkg::*;

    int      assertFails = 0;
    dramCmdT pinCmd;
    logic    seenModeSet;
    logic    seenPrecharge;
    int      refreshGap;        // cycles since the last refresh on the pins

    assign pinCmd = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            seenModeSet   <= 1'b0;
            seenPrecharge <= 1'b0;
            refreshGap    <= 0;
        end else begin
            if (pinCmd == CmdModeSet)      seenModeSet <= 1'b1;
            if (pinCmd == CmdPrechargeAll) seenPrecharge <= 1'b1;
            refreshGap <= (pinCmd == CmdAutoRefresh || !ResetOut_L) ? 0 : refreshGap + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // init, mapping, refresh, handshake, data bus
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge Clock) disable iff (!Reset_L) ResetOut_L |-> seenModeSet)
        else begin assertFails++; $error("cpu reset released before mode set"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     pinCmd == CmdModeSet |-> SdramAddr == ModeRegValue)
        else begin assertFails++; $error("wrong mode register value"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     pinCmd == CmdPrechargeAll |-> SdramAddr[10])
        else begin assertFails++; $error("precharge all without A10"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     pinCmd == CmdAutoRefresh |-> seenPrecharge)
        else begin assertFails++; $error("refresh before the first precharge"); end
    assert property (@(posedge Clock) disable iff (!Reset_L) pinCmd == CmdActivate |->
                     SdramAddr == Address[RowMsb:RowLsb] && SdramBa == Address[BankMsb:BankLsb])
        else begin assertFails++; $error("activate row or bank mismatch"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     (pinCmd == CmdRead || pinCmd == CmdWrite) |->
                     SdramBa == Address[BankMsb:BankLsb] && SdramAddr[10] &&
                     SdramAddr[9:0] == Address[ColMsb:ColLsb])
        else begin assertFails++; $error("read or write column mismatch"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     ResetOut_L && pinCmd == CmdAutoRefresh |-> $past(pinCmd, 2) == CmdPrechargeAll)
        else begin assertFails++; $error("idle refresh without precharge"); end
    assert property (@(posedge Clock) disable iff (!Reset_L) refreshGap <= RefreshPeriod + 40)
        else begin assertFails++; $error("refresh interval too long"); end
    assert property (@(posedge Clock) disable iff (!Reset_L) !Dtack_L |-> ResetOut_L)
        else begin assertFails++; $error("dtack during cpu reset"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     !Dtack_L && (!UDS_L || !LDS_L) |=> !Dtack_L)
        else begin assertFails++; $error("dtack released while strobes low"); end
    assert property (@(posedge Clock) disable iff (!Reset_L) UDS_L && LDS_L |=> Dtack_L)
        else begin assertFails++; $error("dtack held after strobes released"); end
    assert property (@(posedge Clock) disable iff (!Reset_L)
                     SdramDqOe |-> pinCmd == CmdWrite || $past(pinCmd) == CmdWrite)
        else begin assertFails++; $error("dq driven outside a write"); end

endmodule

//--- sim/m68kDramControllerTb.sv
`timescale 1ns/1ps

module m68kDramControllerTb;
    import dramCtrlPkg::*;

    localparam int PairCount     = 12;
    localparam int TimeoutCycles = 20 * RefreshPeriod + 60 * 2 * PairCount;

    logic     Clock;
    logic     Reset_L;
    cpuAddrT  Address;
    wordT     DataIn;
    logic     UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
    wordT     DataOut;
    logic     Dtack_L, ResetOut_L;
    logic     SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L;
    dramAddrT SdramAddr;
    bankT     SdramBa;
    wordT     SdramDqOut, SdramDqIn;
    logic     SdramDqOe;

    int          dataErrors    = 0;
    int          timeoutErrors = 0;
    int          cycleCount    = 0;
    logic [31:0] lcgState      = 32'd54766;
    wordT        expectedWord [cpuAddrT];    // last word written per address

    m68kDramController i_dut (.*);

    sdramModel i_model (
        .Clock, .SdramCke, .SdramCs_L, .SdramRas_L, .SdramCas_L, .SdramWe_L,
        .SdramAddr, .SdramBa, .SdramDqOut, .SdramDqOe, .SdramDqIn
    );

    bind m68kDramController m68kDramController_properties i_props (
        .Clock, .Reset_L, .Address, .UDS_L, .LDS_L, .Dtack_L, .ResetOut_L,
        .SdramCke, .SdramCs_L, .SdramRas_L, .SdramCas_L, .SdramWe_L,
        .SdramAddr, .SdramBa, .SdramDqOe
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic reportAndFinish();
        int total;
        total = i_model.modelErrors + i_dut.i_props.assertFails + timeoutErrors + dataErrors;
        $display("model errors %0d, assertion errors %0d, timeout errors %0d, data errors %0d",
                 i_model.modelErrors, i_dut.i_props.assertFails, timeoutErrors, dataErrors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge Clock);
        #2;
    endtask

    task automatic waitDtack(input logic level);
        do waitCycles(1); while (Dtack_L !== level);
    endtask

    // one 68000 bus cycle, strobes held a few cycles past dtack
    task automatic busCycle(input cpuAddrT addr, input logic write, input wordT data,
                            input int hold);
        Address      = addr;
        DataIn       = data;
        WE_L         = !write;
        AS_L         = 1'b0;
        DramSelect_L = 1'b0;
        UDS_L        = 1'b0;
        LDS_L        = 1'b0;
        waitDtack(1'b0);
        waitCycles(2 + hold);
        AS_L         = 1'b1;
        DramSelect_L = 1'b1;
        UDS_L        = 1'b1;
        LDS_L        = 1'b1;
        waitDtack(1'b1);
    endtask

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // timeout guard
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            timeoutErrors++;
            $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
            reportAndFinish();
        end
    end

    initial begin
        cpuAddrT     addr;
        wordT        data;
        logic [31:0] r;
        Reset_L = 1'b0;
        Address = '0;
        DataIn  = '0;
        // bus request during init that the controller must ignore
        {UDS_L, LDS_L, DramSelect_L, WE_L, AS_L} = 5'b00010;
        repeat (16) @(posedge Clock);
        #2 Reset_L = 1'b1;
        waitCycles(20);
        {UDS_L, LDS_L, DramSelect_L, WE_L, AS_L} = 5'b11111;

        do waitCycles(1); while (ResetOut_L !== 1'b1);    // init done

        for (int i = 0; i < PairCount; i++) begin
            r    = nextRandom();
            addr = {6'b0, r[30:6], 1'b0};
            r    = nextRandom();
            data = r[31:16];
            busCycle(addr, 1'b1, data, int'(r[5:4]));
            expectedWord[addr] = data;
            r = nextRandom();
            waitCycles(int'(r[10:8]));
            busCycle(addr, 1'b0, '0, int'(r[5:4]));
            assert (DataOut === expectedWord[addr]) else begin
                dataErrors++;
                $display("ERR %0t: read at %h gave %h, expected %h",
                         $time, addr, DataOut, expectedWord[addr]);
            end
            waitCycles(int'(r[14:12]));
        end

        waitCycles(2 * RefreshPeriod + 20);    // idle refreshes
        reportAndFinish();
    end

endmodule

//--- m68kDramController.f
hw/dramCtrlPkg.sv
hw/dramTimers.sv
hw/dramSequencer.sv
hw/dramPinDriver.sv
hw/m68kDramController.sv
sim/sdramModel.sv
sim/m68kDramController_properties.sv
sim/m68kDramControllerTb.sv

//--- runSim.sh
#!/bin/sh
# build and run with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module m68kDramControllerTb \
    -f m68kDramController.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "%Error" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
